// File: logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    // bus widths
    localparam int DATA_W = 8;
    localparam int ADDR_W = 16;

    // status register bit positions
    localparam int FL_C = 0;
    localparam int FL_Z = 1;
    localparam int FL_I = 2;
    localparam int FL_D = 3;
    localparam int FL_B = 4;
    localparam int FL_U = 5;
    localparam int FL_V = 6;
    localparam int FL_N = 7;

    // bits 5 and 4 read back as one
    localparam logic [DATA_W-1:0] STATUS_U_MASK =
        (8'h01 << FL_U) | (8'h01 << FL_B);

    // opcodes the core accepts, everything else jams
    typedef enum logic [7:0] {
        LDA_IMM = 8'hA9, LDX_IMM = 8'hA2, LDY_IMM = 8'hA0,
        ADC_IMM = 8'h69, SBC_IMM = 8'hE9,
        AND_IMM = 8'h29, ORA_IMM = 8'h09, EOR_IMM = 8'h49,
        CMP_IMM = 8'hC9, CPX_IMM = 8'hE0, CPY_IMM = 8'hC0,
        TAX = 8'hAA, TAY = 8'hA8, TXA = 8'h8A, TYA = 8'h98,
        TSX = 8'hBA, TXS = 8'h9A,
        INX = 8'hE8, INY = 8'hC8, DEX = 8'hCA, DEY = 8'h88,
        ASL_A = 8'h0A, LSR_A = 8'h4A, ROL_A = 8'h2A, ROR_A = 8'h6A,
        CLC = 8'h18, SEC = 8'h38, CLI = 8'h58, SEI = 8'h78,
        CLV = 8'hB8, CLD = 8'hD8, SED = 8'hF8, NOP = 8'hEA
    } opcode_t;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_AND, ALU_ORA, ALU_EOR,
        ALU_ASL, ALU_LSR, ALU_ROL, ALU_ROR, ALU_PASS
    } alu_op_t;

    typedef enum logic [2:0] {REG_A, REG_X, REG_Y, REG_S, REG_NONE} reg_sel_t;

    typedef enum logic [1:0] {B_OPERAND, B_ZERO, B_ONE, B_ONES} b_sel_t;

    typedef enum logic [1:0] {CI_ZERO, CI_ONE, CI_FLAG} carry_sel_t;

    typedef enum logic [1:0] {PH_OPCODE, PH_OPERAND, PH_JAM} fetch_phase_t;

    // execute control word, one per issued instruction
    typedef struct packed {
        alu_op_t           alu_op;
        reg_sel_t          src;
        b_sel_t            b_sel;
        logic              b_invert;
        carry_sel_t        carry_sel;
        reg_sel_t          dst;
        logic              set_nz;
        logic              set_c;
        logic              set_v;
        logic [DATA_W-1:0] set_mask;
        logic [DATA_W-1:0] clear_mask;
    } exe_ctl_t;

    // architectural register view
    typedef struct packed {
        logic [ADDR_W-1:0] pc;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] x;
        logic [DATA_W-1:0] y;
        logic [DATA_W-1:0] s;
        logic [DATA_W-1:0] p;
    } reg_view_t;

endpackage

`default_nettype wire

// File: logic/cpu_alu.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_alu (
    input  logic [cpu_pkg::DATA_W-1:0] ai,
    input  logic [cpu_pkg::DATA_W-1:0] bi,
    input  logic                       ci,
    input  cpu_pkg::alu_op_t           op,
    output logic [cpu_pkg::DATA_W-1:0] result,
    output logic                       n,
    output logic                       v,
    output logic                       z,
    output logic                       c
);
    import cpu_pkg::*;

    // carry out in the top bit
    logic [DATA_W:0] sum;

    assign sum = {1'b0, ai} + {1'b0, bi} + {{DATA_W{1'b0}}, ci};

    always_comb begin
        // pass: unused side is held at zero by execute
        result = ai | bi;
        c      = 1'b0;
        v      = 1'b0;
        case (op)
            ALU_ADD: begin
                result = sum[DATA_W-1:0];
                c      = sum[DATA_W];
                // operands agree in sign, result does not
                v      = (ai[DATA_W-1] == bi[DATA_W-1]) &&
                         (sum[DATA_W-1] != ai[DATA_W-1]);
            end
            ALU_AND: result = ai & bi;
            ALU_ORA: result = ai | bi;
            ALU_EOR: result = ai ^ bi;
            ALU_ASL: begin
                result = {ai[DATA_W-2:0], 1'b0};
                c      = ai[DATA_W-1];
            end
            ALU_LSR: begin
                result = {1'b0, ai[DATA_W-1:1]};
                c      = ai[0];
            end
            // rotates go through the carry
            ALU_ROL: begin
                result = {ai[DATA_W-2:0], ci};
                c      = ai[DATA_W-1];
            end
            ALU_ROR: begin
                result = {ci, ai[DATA_W-1:1]};
                c      = ai[0];
            end
            default: begin
            end
        endcase
    end

    assign n = result[DATA_W-1];
    assign z = (result == '0);

endmodule

`default_nettype wire

// File: logic/cpu_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_fetch #(
    parameter logic [cpu_pkg::ADDR_W-1:0] RESET_PC = 16'h0200
) (
    input  logic                        clk_m1,
    input  logic                        rst,
    input  logic                        ready,
    input  logic [cpu_pkg::DATA_W-1:0]  data_i,
    input  logic                        two_byte,
    input  logic                        illegal,
    output logic [cpu_pkg::ADDR_W-1:0]  addr,
    output logic                        sync,
    output logic                        jam,
    output cpu_pkg::opcode_t            ir,
    output logic [cpu_pkg::DATA_W-1:0]  operand,
    output logic [cpu_pkg::ADDR_W-1:0]  pc
);
    import cpu_pkg::*;

    fetch_phase_t phase;

    // memory answers in the same cycle, so pc goes straight out
    assign addr = pc;
    assign sync = (phase == PH_OPCODE);
    assign jam  = (phase == PH_JAM);

    // phase sequencing, pc and opcode register
    always_ff @(posedge clk_m1) begin
        if (rst) begin
            phase <= PH_OPCODE;
            pc    <= RESET_PC;
            ir    <= NOP;
        end else if (ready) begin
            case (phase)
                PH_OPCODE: begin
                    ir    <= opcode_t'(data_i);
                    pc    <= pc + 1'b1;
                    phase <= PH_OPERAND;
                end
                PH_OPERAND: begin
                    // implied ops read the next byte but leave pc alone
                    if (two_byte) begin
                        pc <= pc + 1'b1;
                    end
                    phase <= illegal ? PH_JAM : PH_OPCODE;
                end
                // stuck here until reset
                PH_JAM: phase <= PH_JAM;
                default: phase <= PH_JAM;
            endcase
        end
    end

    // second byte, also taken on the dummy read of implied ops
    always_ff @(posedge clk_m1) begin
        if (ready && (phase == PH_OPERAND)) begin
            operand <= data_i;
        end
    end

    // bus frozen during a stall
    a_addr_hold: assert property (@(posedge clk_m1) disable iff (rst)
        !ready |=> $stable(addr))
        else $error("addr moved while ready low");

    a_sync_jam: assert property (@(posedge clk_m1) disable iff (rst)
        !(sync && jam))
        else $error("sync and jam both high");

endmodule

`default_nettype wire

// File: logic/cpu_decode.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_decode (
    input  logic                        clk_m1,
    input  logic                        rst,
    input  logic                        ready,
    input  cpu_pkg::opcode_t            ir,
    input  logic [cpu_pkg::DATA_W-1:0]  operand,
    output logic                        two_byte,
    output logic                        illegal,
    output cpu_pkg::exe_ctl_t           issue_ctl,
    output logic [cpu_pkg::DATA_W-1:0]  issue_operand,
    output logic                        issue_valid
);
    import cpu_pkg::*;

    exe_ctl_t ctl;
    logic     compare;
    // mirrors the fetch phase and is high in the operand cycle
    logic     operand_cycle;

    assign compare = (ir == CMP_IMM) || (ir == CPX_IMM) || (ir == CPY_IMM);

    always_comb begin
        two_byte = 1'b0;
        illegal  = 1'b0;
        // instruction length and legality
        case (ir)
            LDA_IMM, LDX_IMM, LDY_IMM, ADC_IMM, SBC_IMM, AND_IMM, ORA_IMM,
            EOR_IMM, CMP_IMM, CPX_IMM, CPY_IMM: two_byte = 1'b1;
            TAX, TAY, TXA, TYA, TSX, TXS, INX, INY, DEX, DEY,
            ASL_A, LSR_A, ROL_A, ROR_A, CLC, SEC, CLI, SEI,
            CLV, CLD, SED, NOP: two_byte = 1'b0;
            default: illegal = 1'b1;
        endcase

        // register read into the alu a input
        case (ir)
            ADC_IMM, SBC_IMM, AND_IMM, ORA_IMM, EOR_IMM, CMP_IMM,
            TAX, TAY, ASL_A, LSR_A, ROL_A, ROR_A: ctl.src = REG_A;
            CPX_IMM, TXA, TXS, INX, DEX: ctl.src = REG_X;
            CPY_IMM, TYA, INY, DEY: ctl.src = REG_Y;
            TSX: ctl.src = REG_S;
            default: ctl.src = REG_NONE;
        endcase

        // register written at commit
        case (ir)
            LDA_IMM, ADC_IMM, SBC_IMM, AND_IMM, ORA_IMM, EOR_IMM,
            TXA, TYA, ASL_A, LSR_A, ROL_A, ROR_A: ctl.dst = REG_A;
            LDX_IMM, TAX, TSX, INX, DEX: ctl.dst = REG_X;
            LDY_IMM, TAY, INY, DEY: ctl.dst = REG_Y;
            TXS: ctl.dst = REG_S;
            default: ctl.dst = REG_NONE;
        endcase

        // alu function, b input and carry in
        ctl.alu_op    = ALU_PASS;
        ctl.b_sel     = two_byte ? B_OPERAND : B_ZERO;
        ctl.b_invert  = 1'b0;
        ctl.carry_sel = CI_ZERO;
        case (ir)
            ADC_IMM: begin
                ctl.alu_op    = ALU_ADD;
                ctl.carry_sel = CI_FLAG;
            end
            // a + ~m + c
            SBC_IMM: begin
                ctl.alu_op    = ALU_ADD;
                ctl.b_invert  = 1'b1;
                ctl.carry_sel = CI_FLAG;
            end
            // subtract without borrow and drop the result
            CMP_IMM, CPX_IMM, CPY_IMM: begin
                ctl.alu_op    = ALU_ADD;
                ctl.b_invert  = 1'b1;
                ctl.carry_sel = CI_ONE;
            end
            AND_IMM: ctl.alu_op = ALU_AND;
            ORA_IMM: ctl.alu_op = ALU_ORA;
            EOR_IMM: ctl.alu_op = ALU_EOR;
            INX, INY: begin
                ctl.alu_op = ALU_ADD;
                ctl.b_sel  = B_ONE;
            end
            // add 0xff
            DEX, DEY: begin
                ctl.alu_op = ALU_ADD;
                ctl.b_sel  = B_ONES;
            end
            ASL_A: ctl.alu_op = ALU_ASL;
            LSR_A: ctl.alu_op = ALU_LSR;
            ROL_A: begin
                ctl.alu_op    = ALU_ROL;
                ctl.carry_sel = CI_FLAG;
            end
            ROR_A: begin
                ctl.alu_op    = ALU_ROR;
                ctl.carry_sel = CI_FLAG;
            end
            default: ctl.alu_op = ALU_PASS;
        endcase

        // TXS is the one transfer that leaves n/z alone
        ctl.set_nz = ((ctl.dst != REG_NONE) && (ir != TXS)) || compare;
        ctl.set_c  = (ir == ADC_IMM) || (ir == SBC_IMM) || compare ||
                     (ir == ASL_A) || (ir == LSR_A) || (ir == ROL_A) || (ir == ROR_A);
        ctl.set_v  = (ir == ADC_IMM) || (ir == SBC_IMM);

        // flag ops
        ctl.set_mask   = '0;
        ctl.clear_mask = '0;
        case (ir)
            CLC: ctl.clear_mask[FL_C] = 1'b1;
            SEC: ctl.set_mask[FL_C]   = 1'b1;
            CLI: ctl.clear_mask[FL_I] = 1'b1;
            SEI: ctl.set_mask[FL_I]   = 1'b1;
            CLV: ctl.clear_mask[FL_V] = 1'b1;
            CLD: ctl.clear_mask[FL_D] = 1'b1;
            SED: ctl.set_mask[FL_D]   = 1'b1;
            default: ctl.set_mask = '0;
        endcase
    end

    always_ff @(posedge clk_m1) begin
        if (rst) begin
            operand_cycle <= 1'b0;
            issue_valid   <= 1'b0;
        end else if (ready) begin
            operand_cycle <= !operand_cycle;
            issue_valid   <= operand_cycle && !illegal;
        end
    end

    // control word for the execute cycle
    always_ff @(posedge clk_m1) begin
        if (ready && operand_cycle && !illegal) begin
            issue_ctl <= ctl;
        end
    end

    // fetch captures the operand at this same edge
    assign issue_operand = operand;

    // nothing in execute while ir holds a jam opcode
    a_no_illegal_issue: assert property (@(posedge clk_m1) disable iff (rst)
        illegal |-> !issue_valid)
        else $error("illegal opcode issued");

endmodule

`default_nettype wire

// File: logic/cpu_execute.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_execute #(
    parameter logic [cpu_pkg::DATA_W-1:0] INITIAL_STACK  = 8'hfd,
    parameter logic [cpu_pkg::DATA_W-1:0] INITIAL_STATUS = 8'h34
) (
    input  logic                        clk_m1,
    input  logic                        rst,
    input  logic                        ready,
    input  cpu_pkg::exe_ctl_t           issue_ctl,
    input  logic [cpu_pkg::DATA_W-1:0]  issue_operand,
    input  logic                        issue_valid,
    output cpu_pkg::reg_view_t          regs
);
    import cpu_pkg::*;

    logic [DATA_W-1:0] a, x, y, s, p;
    logic [DATA_W-1:0] ai, b_raw, bi, result, p_next;
    logic              ci, alu_n, alu_v, alu_z, alu_c;
    logic              commit;

    assign commit = issue_valid && ready;

    // a input from the register file, zero when none
    always_comb begin
        case (issue_ctl.src)
            REG_A: ai = a;
            REG_X: ai = x;
            REG_Y: ai = y;
            REG_S: ai = s;
            default: ai = '0;
        endcase
    end

    // b input and optional inversion for subtract
    always_comb begin
        case (issue_ctl.b_sel)
            B_OPERAND: b_raw = issue_operand;
            B_ONE: b_raw = {{(DATA_W-1){1'b0}}, 1'b1};
            B_ONES: b_raw = '1;
            default: b_raw = '0;
        endcase
    end
    assign bi = issue_ctl.b_invert ? ~b_raw : b_raw;

    always_comb begin
        case (issue_ctl.carry_sel)
            CI_ONE: ci = 1'b1;
            CI_FLAG: ci = p[FL_C];
            default: ci = 1'b0;
        endcase
    end

    cpu_alu u_alu (
        .ai     (ai),
        .bi     (bi),
        .ci     (ci),
        .op     (issue_ctl.alu_op),
        .result (result),
        .n      (alu_n),
        .v      (alu_v),
        .z      (alu_z),
        .c      (alu_c)
    );

    // masks first, then alu flags on top
    always_comb begin
        p_next = (p & ~issue_ctl.clear_mask) | issue_ctl.set_mask;
        if (issue_ctl.set_nz) begin
            p_next[FL_N] = alu_n;
            p_next[FL_Z] = alu_z;
        end
        if (issue_ctl.set_c) begin
            p_next[FL_C] = alu_c;
        end
        if (issue_ctl.set_v) begin
            p_next[FL_V] = alu_v;
        end
        p_next = p_next | STATUS_U_MASK;
    end

    always_ff @(posedge clk_m1) begin
        if (rst) begin
            a <= '0;
            x <= '0;
            y <= '0;
            s <= INITIAL_STACK;
            p <= INITIAL_STATUS | STATUS_U_MASK;
        end else if (commit) begin
            p <= p_next;
            case (issue_ctl.dst)
                REG_A: a <= result;
                REG_X: x <= result;
                REG_Y: y <= result;
                REG_S: s <= result;
                default: begin
                end
            endcase
        end
    end

    // pc slot filled in by the core
    always_comb begin
        regs    = '0;
        regs.a  = a;
        regs.x  = x;
        regs.y  = y;
        regs.s  = s;
        regs.p  = p;
    end

    a_status_u: assert property (@(posedge clk_m1) disable iff (rst)
        p[FL_U])
        else $error("status bit 5 cleared");

endmodule

`default_nettype wire

// File: logic/cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_core #(
    parameter logic [cpu_pkg::ADDR_W-1:0] RESET_PC       = 16'h0200,
    parameter logic [cpu_pkg::DATA_W-1:0] INITIAL_STACK  = 8'hfd,
    parameter logic [cpu_pkg::DATA_W-1:0] INITIAL_STATUS = 8'h34
) (
    input  logic                        clk_m1,
    input  logic                        rst,
    input  logic                        ready,
    input  logic [cpu_pkg::DATA_W-1:0]  data_i,
    output logic [cpu_pkg::ADDR_W-1:0]  addr,
    output logic                        sync,
    output logic                        jam,
    output cpu_pkg::reg_view_t          regs
);
    import cpu_pkg::*;

    // fetch <-> decode
    opcode_t           ir;
    logic [DATA_W-1:0] operand;
    logic              two_byte, illegal;
    logic [ADDR_W-1:0] pc;

    // decode -> execute
    exe_ctl_t          issue_ctl;
    logic [DATA_W-1:0] issue_operand;
    logic              issue_valid;
    reg_view_t         exe_regs;

    cpu_fetch #(
        .RESET_PC (RESET_PC)
    ) u_fetch (
        .clk_m1   (clk_m1),
        .rst      (rst),
        .ready    (ready),
        .data_i   (data_i),
        .two_byte (two_byte),
        .illegal  (illegal),
        .addr     (addr),
        .sync     (sync),
        .jam      (jam),
        .ir       (ir),
        .operand  (operand),
        .pc       (pc)
    );

    cpu_decode u_decode (
        .clk_m1        (clk_m1),
        .rst           (rst),
        .ready         (ready),
        .ir            (ir),
        .operand       (operand),
        .two_byte      (two_byte),
        .illegal       (illegal),
        .issue_ctl     (issue_ctl),
        .issue_operand (issue_operand),
        .issue_valid   (issue_valid)
    );

    cpu_execute #(
        .INITIAL_STACK  (INITIAL_STACK),
        .INITIAL_STATUS (INITIAL_STATUS)
    ) u_execute (
        .clk_m1        (clk_m1),
        .rst           (rst),
        .ready         (ready),
        .issue_ctl     (issue_ctl),
        .issue_operand (issue_operand),
        .issue_valid   (issue_valid),
        .regs          (exe_regs)
    );

    // execute registers plus the fetch pc
    always_comb begin
        regs    = exe_regs;
        regs.pc = pc;
    end

endmodule

`default_nettype wire

// File: verification/tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 5
) (
    input  logic restart,
    output logic clk_m1,
    output logic rst
);
    // reset is held while the count runs down
    int rst_cnt = RESET_CYCLES;

    initial begin
        clk_m1 = 1'b0;
        forever #(PERIOD / 2) clk_m1 = ~clk_m1;
    end

    // restart reloads the count for another reset pulse
    always @(posedge clk_m1) begin
        if (restart) begin
            rst_cnt <= RESET_CYCLES;
        end else if (rst_cnt != 0) begin
            rst_cnt <= rst_cnt - 1;
        end
    end

    assign rst = (rst_cnt != 0);

endmodule

`default_nettype wire

// File: verification/tb_program.svh
`ifndef TB_PROGRAM_SVH
`define TB_PROGRAM_SVH

// byte images of the two programs, loaded at RESET_PC
logic [7:0] dir_prog[$];
logic [7:0] rnd_prog[$];

// opcodes with an immediate byte
function automatic logic takes_operand(input logic [7:0] op);
    case (op)
        8'hA9, 8'hA2, 8'hA0, 8'h69, 8'hE9, 8'h29, 8'h09, 8'h49,
        8'hC9, 8'hE0, 8'hC0: return 1'b1;
        default: return 1'b0;
    endcase
endfunction

function automatic logic is_kept(input logic [7:0] op);
    case (op)
        8'hAA, 8'hA8, 8'h8A, 8'h98, 8'hBA, 8'h9A, 8'hE8, 8'hC8, 8'hCA, 8'h88,
        8'h0A, 8'h4A, 8'h2A, 8'h6A, 8'h18, 8'h38, 8'h58, 8'h78,
        8'hB8, 8'hD8, 8'hF8, 8'hEA: return 1'b1;
        default: return takes_operand(op);
    endcase
endfunction

// n and z from a result byte
function automatic logic [7:0] with_nz(input logic [7:0] pv, input logic [7:0] r);
    logic [7:0] q;
    q    = pv;
    q[7] = r[7];
    q[1] = (r == 8'h00);
    return q;
endfunction

// opcode mix for the random arithmetic run
function automatic logic [7:0] random_op(input int k);
    case (k)
        0: return 8'hA9;
        1: return 8'hA2;
        2: return 8'hA0;
        3, 4: return 8'h69;
        5, 6: return 8'hE9;
        7: return 8'hC9;
        8: return 8'hE0;
        9: return 8'hC0;
        10: return 8'h29;
        11: return 8'h09;
        12: return 8'h49;
        13: return 8'h0A;
        14: return 8'h4A;
        15: return 8'h2A;
        16: return 8'h6A;
        17: return 8'h38;
        default: return 8'h18;
    endcase
endfunction

task automatic build_programs();
    logic [7:0] op;
    // loads, transfers, inc/dec, flag ops, then a jam opcode
    dir_prog = '{8'hA2, 8'h05, 8'hA0, 8'h80, 8'hA9, 8'h00, 8'hAA, 8'hE8, 8'hE8,
                 8'hCA, 8'hC8, 8'h88, 8'h88, 8'h8A, 8'h98, 8'hA8, 8'hBA,
                 8'hA2, 8'h40, 8'h9A, 8'hBA, 8'h38, 8'hF8, 8'h78, 8'hB8,
                 8'h18, 8'hD8, 8'h58, 8'h38, 8'hEA, 8'h02};
    rnd_prog.delete();
    for (int k = 0; k < 48; k++) begin
        op = random_op($unsigned($random(seed)) % 19);
        rnd_prog.push_back(op);
        if (takes_operand(op)) begin
            rnd_prog.push_back(8'($random(seed)));
        end
    end
    rnd_prog.push_back(8'h02);
endtask

// walks the image in mem, fills exp_sync_addrs and exp_regs
task automatic model_program();
    logic [15:0] pc;
    logic [7:0]  op, m, r, a, x, y, s, p;
    logic [8:0]  sum;
    logic        done;
    pc   = RESET_PC;
    a    = 8'h00;
    x    = 8'h00;
    y    = 8'h00;
    s    = INITIAL_STACK;
    p    = INITIAL_STATUS | 8'h30;
    done = 1'b0;
    exp_sync_addrs.delete();
    while (!done && exp_sync_addrs.size() < 1000) begin
        op = mem[pc];
        m  = mem[pc + 16'd1];
        exp_sync_addrs.push_back(pc);
        pc = pc + (takes_operand(op) ? 16'd2 : 16'd1);
        case (op)
            8'hA9: begin a = m; p = with_nz(p, a); end
            8'hA2: begin x = m; p = with_nz(p, x); end
            8'hA0: begin y = m; p = with_nz(p, y); end
            8'h69, 8'hE9: begin
                // subtract adds the complement
                if (op == 8'hE9) m = ~m;
                sum  = {1'b0, a} + {1'b0, m} + {8'h00, p[0]};
                r    = sum[7:0];
                p[6] = (a[7] == m[7]) && (r[7] != a[7]);
                p[0] = sum[8];
                a    = r;
                p    = with_nz(p, a);
            end
            8'hC9, 8'hE0, 8'hC0: begin
                r    = (op == 8'hC9) ? a : ((op == 8'hE0) ? x : y);
                sum  = {1'b0, r} + {1'b0, ~m} + 9'd1;
                p[0] = sum[8];
                p    = with_nz(p, sum[7:0]);
            end
            8'h29: begin a = a & m; p = with_nz(p, a); end
            8'h09: begin a = a | m; p = with_nz(p, a); end
            8'h49: begin a = a ^ m; p = with_nz(p, a); end
            8'hAA: begin x = a; p = with_nz(p, x); end
            8'hA8: begin y = a; p = with_nz(p, y); end
            8'h8A: begin a = x; p = with_nz(p, a); end
            8'h98: begin a = y; p = with_nz(p, a); end
            8'hBA: begin x = s; p = with_nz(p, x); end
            8'h9A: s = x;
            8'hE8: begin x = x + 8'd1; p = with_nz(p, x); end
            8'hC8: begin y = y + 8'd1; p = with_nz(p, y); end
            8'hCA: begin x = x - 8'd1; p = with_nz(p, x); end
            8'h88: begin y = y - 8'd1; p = with_nz(p, y); end
            8'h0A: begin p[0] = a[7]; a = {a[6:0], 1'b0}; p = with_nz(p, a); end
            8'h4A: begin p[0] = a[0]; a = {1'b0, a[7:1]}; p = with_nz(p, a); end
            8'h2A: begin r = {a[6:0], p[0]}; p[0] = a[7]; a = r; p = with_nz(p, a); end
            8'h6A: begin r = {p[0], a[7:1]}; p[0] = a[0]; a = r; p = with_nz(p, a); end
            8'h18: p[0] = 1'b0;
            8'h38: p[0] = 1'b1;
            8'h58: p[2] = 1'b0;
            8'h78: p[2] = 1'b1;
            8'hB8: p[6] = 1'b0;
            8'hD8: p[3] = 1'b0;
            8'hF8: p[3] = 1'b1;
            8'hEA: begin end
            // jam, pc stops one past the opcode
            default: done = 1'b1;
        endcase
    end
    exp_regs = {pc, a, x, y, s, p};
endtask

`endif

// File: verification/tb_cpu_core.sv
`timescale 1ns/1ps
`default_nettype none

module tb_cpu_core;
    import cpu_pkg::*;

    localparam logic [15:0] RESET_PC       = 16'h0300;
    localparam logic [7:0]  INITIAL_STACK  = 8'hff;
    localparam logic [7:0]  INITIAL_STATUS = 8'h24;
    localparam reg_view_t   RESET_VIEW     =
        {RESET_PC, 8'h00, 8'h00, 8'h00, INITIAL_STACK, INITIAL_STATUS | 8'h30};

    logic clk_m1, rst, restart, ready, sync, jam, stall_on;
    logic [7:0]  data_i;
    logic [15:0] addr, exp_sync_addr;
    reg_view_t   regs, exp_regs;
    logic [7:0]  mem [0:65535];
    logic [15:0] exp_sync_addrs[$];
    integer      seed = 32'heec4;
    int sync_idx, ill_cnt, cycles, cycle_limit, error_count, tests_ok, tests_bad;

    `include "tb_program.svh"

    tb_clock #(.PERIOD(10), .RESET_CYCLES(5)) u_clock (
        .restart (restart), .clk_m1 (clk_m1), .rst (rst)
    );

    cpu_core #(
        .RESET_PC (RESET_PC), .INITIAL_STACK (INITIAL_STACK),
        .INITIAL_STATUS (INITIAL_STATUS)
    ) UUT (
        .clk_m1 (clk_m1), .rst (rst), .ready (ready), .data_i (data_i),
        .addr (addr), .sync (sync), .jam (jam), .regs (regs)
    );

    // memory answers in the same cycle
    assign data_i = mem[addr];

    always @(posedge clk_m1) begin
        ready <= stall_on ? (($random(seed) & 3) != 0) : 1'b1;
        // next expected opcode address
        if (rst) begin
            exp_sync_addr <= exp_sync_addrs[0];
            sync_idx      <= 1;
        end else if (sync && ready) begin
            exp_sync_addr <= exp_sync_addrs[sync_idx];
            sync_idx      <= sync_idx + 1;
        end
        // ready cycles since an illegal opcode was fetched
        if (rst) begin
            ill_cnt <= 0;
        end else if (ready) begin
            if (sync && !is_kept(data_i)) ill_cnt <= 1;
            else if (ill_cnt == 1) ill_cnt <= 2;
        end
        cycles <= cycles + 1;
        if (cycle_limit != 0 && cycles >= cycle_limit) begin
            $display("timeout: core never reached jam within %0d cycles", cycle_limit);
            $display("Simulation failed");
            $finish;
        end
    end

    a_reset_addr: assert property (@(posedge clk_m1) $fell(rst) |-> addr == RESET_PC)
        else begin
            error_count++;
            $display("FAILED %0t addr exp %h got %h", $time, RESET_PC, $sampled(addr));
        end
    a_reset_bus: assert property (@(posedge clk_m1) $fell(rst) |-> sync && !jam)
        else begin
            error_count++;
            $display("error %0t: sync low or jam high after reset", $time);
        end
    a_reset_regs: assert property (@(posedge clk_m1) $fell(rst) |-> regs == RESET_VIEW)
        else begin
            error_count++;
            $display("FAILED %0t regs exp %h got %h", $time, RESET_VIEW, $sampled(regs));
        end
    a_sync_drop: assert property (@(posedge clk_m1) disable iff (rst)
        sync && ready |=> !sync)
        else begin
            error_count++;
            $display("error %0t: sync stayed high after opcode cycle", $time);
        end
    a_sync_return: assert property (@(posedge clk_m1) disable iff (rst)
        !sync && !jam && ready |=> sync || jam)
        else begin
            error_count++;
            $display("error %0t: no opcode fetch after operand cycle", $time);
        end
    a_sync_addr: assert property (@(posedge clk_m1) disable iff (rst)
        sync |-> addr == exp_sync_addr)
        else begin
            error_count++;
            $display("FAILED %0t addr exp %h got %h", $time,
                $sampled(exp_sync_addr), $sampled(addr));
        end
    a_stall_hold: assert property (@(posedge clk_m1) disable iff (rst)
        !ready |=> $stable(addr) && $stable(sync))
        else begin
            error_count++;
            $display("error %0t: addr or sync moved during a stall", $time);
        end
    a_jam_early: assert property (@(posedge clk_m1) disable iff (rst)
        ill_cnt == 1 |-> !jam)
        else begin
            error_count++;
            $display("error %0t: jam rose one cycle after the illegal fetch", $time);
        end
    a_jam_rise: assert property (@(posedge clk_m1) disable iff (rst)
        ill_cnt == 2 |-> jam)
        else begin
            error_count++;
            $display("error %0t: jam not high two cycles after illegal fetch", $time);
        end
    a_jam_hold: assert property (@(posedge clk_m1) disable iff (rst)
        jam |=> jam && !sync && $stable(addr) && $stable(regs))
        else begin
            error_count++;
            $display("error %0t: core left the jam state or changed state", $time);
        end
    a_final_regs: assert property (@(posedge clk_m1) disable iff (rst)
        $rose(jam) |-> regs == exp_regs)
        else begin
            error_count++;
            $display("FAILED %0t regs exp %h got %h", $time,
                $sampled(exp_regs), $sampled(regs));
        end

    // fills memory, loads one image, runs it to jam plus 20 held cycles
    task automatic run_program(input string name, input bit use_rnd, input bit stalls,
                               input bit first);
        logic [15:0] fa;
        int errors_before;
        errors_before = error_count;
        for (int i = 0; i < 65536; i++) begin
            fa     = i[15:0];
            mem[i] = fa[15:8] ^ fa[7:0] ^ 8'h5a;
        end
        for (int i = 0; i < (use_rnd ? rnd_prog.size() : dir_prog.size()); i++) begin
            mem[RESET_PC + i] = use_rnd ? rnd_prog[i] : dir_prog[i];
        end
        model_program();
        stall_on = stalls;
        if (!first) begin
            @(posedge clk_m1);
            restart <= 1'b1;
            @(posedge clk_m1);
            restart <= 1'b0;
        end
        @(posedge clk_m1);
        while (rst) @(posedge clk_m1);
        while (!jam) @(posedge clk_m1);
        repeat (20) @(posedge clk_m1);
        if (error_count == errors_before) begin
            tests_ok++;
            $display("test %s: ok", name);
        end else begin
            tests_bad++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    initial begin
        restart     = 1'b0;
        ready       = 1'b1;
        stall_on    = 1'b0;
        cycles      = 0;
        error_count = 0;
        tests_ok    = 0;
        tests_bad   = 0;
        build_programs();
        // stall run counted like the plain run
        cycle_limit = (5 + 4 * dir_prog.size() + 50) + 2 * (5 + 4 * rnd_prog.size() + 50);
        run_program("directed", 1'b0, 1'b0, 1'b1);
        run_program("random", 1'b1, 1'b0, 1'b0);
        run_program("stalls", 1'b1, 1'b1, 1'b0);
        $display("tests passed %0d, failed %0d, errors %0d", tests_ok, tests_bad, error_count);
        if (tests_bad == 0 && error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+verification
logic/cpu_pkg.sv
logic/cpu_alu.sv
logic/cpu_fetch.sv
logic/cpu_decode.sv
logic/cpu_execute.sv
logic/cpu_core.sv
verification/tb_clock.sv
verification/tb_cpu_core.sv
